// File: include/arith_stream_macros.svh
`ifndef ARITH_STREAM_MACROS_SVH
`define ARITH_STREAM_MACROS_SVH

// operand and result width
`define DATA_W 8

// stages between acceptance and the FIFO write
`define PIPE_DEPTH 4

// FIFO address bits
`define FIFO_K 2

// entries in the output FIFO
`define FIFO_DEPTH (1 << `FIFO_K)

`endif

// File: logic/stream_pkg.sv
`default_nettype none

`include "arith_stream_macros.svh"

package stream_pkg;

  typedef logic [`DATA_W-1:0] data_t;

  // one add/sub request, 17 bits
  typedef struct packed {
    logic  add;   // high adds, low subtracts
    data_t a;
    data_t b;
  } req_t;

  // one result with its flags, 10 bits
  typedef struct packed {
    data_t result;
    logic  z;     // result is zero
    logic  n;     // msb of result
  } rsp_t;

endpackage

`default_nettype wire

// File: logic/flow_pkg.sv
`default_nettype none

`include "arith_stream_macros.svh"

package flow_pkg;

  // FIFO occupancy, 0 up to the full depth
  typedef logic [`FIFO_K:0] level_t;

  // valid items inside the pipeline, 0 up to PIPE_DEPTH
  typedef logic [$clog2(`PIPE_DEPTH+1)-1:0] inflight_t;

  // in-flight plus occupancy, wide enough for both at their maximum
  typedef logic [$clog2(`PIPE_DEPTH+`FIFO_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

// File: logic/skid_buf.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buf #(
  parameter type T = logic
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic us_valid,
  input  wire T     us_data,
  output logic      us_stall,
  output logic      ds_valid,
  output T          ds_data,
  input  wire logic ds_stall
);

  logic stall_q;      // ds_stall seen one cycle late
  logic hold_valid;
  T     hold_data;
  logic pass_valid;
  logic hold_load;

  // upstream only learns about a stall a cycle after it happened
  assign us_stall   = stall_q;
  assign pass_valid = us_valid & ~stall_q;  // item handed over this cycle

  // the held item always goes first
  assign ds_valid = hold_valid | pass_valid;
  assign ds_data  = hold_valid ? hold_data : us_data;

  // handed over but refused downstream
  assign hold_load = ds_stall & pass_valid;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stall_q    <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      stall_q <= ds_stall;
      if (!ds_stall) begin
        hold_valid <= 1'b0;  // entry drained or never used
      end else if (hold_load) begin
        hold_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hold_load) begin
      hold_data <= us_data;
    end
  end

  // a full entry keeps upstream stalled until it has drained
  a_hold_no_overwrite: assert property (
    @(posedge clk) disable iff (rst)
    hold_valid |-> !pass_valid
  ) else $error("skid_buf: new item accepted while hold entry is full");

  // a refused item is offered again, unchanged, in the next cycle
  a_ds_stable: assert property (
    @(posedge clk) disable iff (rst)
    ds_valid && ds_stall |=> ds_valid && $stable(ds_data)
  ) else $error("skid_buf: stalled downstream item changed or vanished");

endmodule

`default_nettype wire

// File: logic/delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter type         T   = logic,
  parameter int unsigned LEN = 1
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire T     d,
  output T          q
);

  generate
    if (LEN == 0) begin : g_wire
      assign q = d;
    end else begin : g_regs
      T stage [LEN];

      always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
          for (int i = 0; i < LEN; i++) begin
            stage[i] <= '0;
          end
        end else begin
          stage[0] <= d;
          for (int i = 1; i < LEN; i++) begin
            stage[i] <= stage[i-1];  // one step per clock
          end
        end
      end

      assign q = stage[LEN-1];
    end
  endgenerate

endmodule

`default_nettype wire

// File: logic/arith_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "arith_stream_macros.svh"

module arith_pipe
  import stream_pkg::*, flow_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   us_valid,
  input  wire req_t   us_data,
  output logic        us_stall,
  input  wire level_t level,
  output logic        wr_valid,
  output rsp_t        wr_data
);

  logic      accept;
  data_t     sum;
  rsp_t      entry_rsp;
  inflight_t inflight;
  credit_t   credit_used;

  // every item in the pipe already owns a FIFO slot
  assign credit_used = credit_t'(inflight) + credit_t'(level);
  assign us_stall    = credit_used >= credit_t'(`FIFO_DEPTH);
  assign accept      = us_valid & ~us_stall;

  // result and flags are formed on entry, the stages only carry them
  assign sum = us_data.add ? us_data.a + us_data.b : us_data.a - us_data.b;

  always_comb begin
    entry_rsp.result = sum;
    entry_rsp.z      = (sum == '0);
    entry_rsp.n      = sum[`DATA_W-1];
  end

  delay_line #(
    .T   (rsp_t),
    .LEN (`PIPE_DEPTH)
  ) u_data_line (
    .clk,
    .rst,
    .d (entry_rsp),
    .q (wr_data)
  );

  // valid chain runs beside the data
  delay_line #(
    .T   (logic),
    .LEN (`PIPE_DEPTH)
  ) u_valid_line (
    .clk,
    .rst,
    .d (accept),
    .q (wr_valid)
  );

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      inflight <= '0;
    end else begin
      case ({accept, wr_valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;  // none or both
      endcase
    end
  end

  // counter tracks the valid chain, so it cannot pass the stage count
  a_inflight_bound: assert property (
    @(posedge clk) disable iff (rst)
    inflight <= inflight_t'(`PIPE_DEPTH)
  ) else $error("arith_pipe: in-flight count above PIPE_DEPTH");

endmodule

`default_nettype wire

// File: logic/out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "arith_stream_macros.svh"

module out_fifo
  import flow_pkg::*;
#(
  parameter type T = logic
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic wr_valid,
  input  wire T     wr_data,
  output logic      rd_valid,
  output T          rd_data,
  input  wire logic rd_stall,
  output level_t    level
);

  localparam int DEPTH = `FIFO_DEPTH;

  // top bit is the wrap bit
  typedef logic [`FIFO_K:0] ptr_t;

  T     mem [DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  logic empty;
  logic full;
  logic do_wr;
  logic do_rd;

  assign empty = (rd_ptr == wr_ptr);
  assign full  = (rd_ptr == {~wr_ptr[`FIFO_K], wr_ptr[`FIFO_K-1:0]});

  assign do_wr = wr_valid & ~full;
  assign do_rd = rd_valid & ~rd_stall;

  assign rd_valid = ~empty;
  assign rd_data  = mem[rd_ptr[`FIFO_K-1:0]];  // head shown straight away
  assign level    = level_t'(wr_ptr - rd_ptr);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[`FIFO_K-1:0]] <= wr_data;
    end
  end

  // the writer's credit rule must keep a free slot for every write
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst)
    wr_valid |-> !full
  ) else $error("out_fifo: write arrived while full");

endmodule

`default_nettype wire

// File: logic/arith_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module arith_stream_top
  import stream_pkg::*, flow_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic in_valid,
  input  wire req_t in_req,
  output logic      in_stall,
  output logic      out_valid,
  output rsp_t      out_rsp,
  input  wire logic out_stall
);

  logic   pipe_valid;
  req_t   pipe_req;
  logic   pipe_stall;
  logic   wr_valid;
  rsp_t   wr_data;
  level_t level;

  skid_buf #(
    .T (req_t)
  ) u_skid (
    .clk,
    .rst,
    .us_valid (in_valid),
    .us_data  (in_req),
    .us_stall (in_stall),
    .ds_valid (pipe_valid),
    .ds_data  (pipe_req),
    .ds_stall (pipe_stall)
  );

  arith_pipe u_pipe (
    .clk,
    .rst,
    .us_valid (pipe_valid),
    .us_data  (pipe_req),
    .us_stall (pipe_stall),
    .level    (level),      // occupancy fed back for credits
    .wr_valid (wr_valid),
    .wr_data  (wr_data)
  );

  out_fifo #(
    .T (rsp_t)
  ) u_fifo (
    .clk,
    .rst,
    .wr_valid (wr_valid),
    .wr_data  (wr_data),
    .rd_valid (out_valid),
    .rd_data  (out_rsp),
    .rd_stall (out_stall),
    .level    (level)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release lands on a falling edge, clear of the sampling edge
  initial begin
    rst = 1'b1;
    #(RESET_CYCLES * PERIOD_NS);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/arith_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "arith_stream_macros.svh"

module arith_stream_tb
  import stream_pkg::*;
();

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_VECS        = 24;
  localparam int HOLD_CYCLES     = 30;
  localparam int WATCHDOG_CYCLES = NUM_VECS * 40 + RESET_CYCLES;

  // one table row: request and the response it must produce
  typedef struct packed {
    logic  add;
    data_t a;
    data_t b;
    data_t result;
    logic  z;
    logic  n;
  } vec_t;

  logic clk;
  logic rst;
  logic in_valid;
  req_t in_req;
  logic in_stall;
  logic out_valid;
  rsp_t out_rsp;
  logic out_stall;

  vec_t        vectors [NUM_VECS];
  int          drv_idx;          // next entry to present
  int          rsp_idx;          // next entry expected at the output
  int          drive_limit;
  int          stall_mode;       // 0 low, 1 held high, 2 random
  int          cycle_no;
  int          acc_cycle;
  int          first_out_cycle;
  logic        idle_check;
  logic        saw_in_stall;
  logic [31:0] lcg_state;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk_gen (
    .clk,
    .rst
  );

  arith_stream_top DUT (
    .clk,
    .rst,
    .in_valid,
    .in_req,
    .in_stall,
    .out_valid,
    .out_rsp,
    .out_stall
  );

  function automatic vec_t make_vec(input logic add, input data_t a, input data_t b,
                                    input data_t result, input logic z, input logic n);
    return {add, a, b, result, z, n};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_response(input vec_t exp, input int idx);
    assert (out_rsp.result == exp.result) else
      abort_run($sformatf("FAILED out_rsp.result (entry %0d): got %h, expected %h",
                          idx, out_rsp.result, exp.result));
    assert (out_rsp.z == exp.z) else
      abort_run($sformatf("FAILED out_rsp.z (entry %0d): got %h, expected %h",
                          idx, out_rsp.z, exp.z));
    assert (out_rsp.n == exp.n) else
      abort_run($sformatf("FAILED out_rsp.n (entry %0d): got %h, expected %h",
                          idx, out_rsp.n, exp.n));
  endtask

  // drive on the falling edge, then sample once everything has settled
  task automatic run_cycle();
    @(negedge clk);
    in_valid = (drv_idx < drive_limit);
    if (drv_idx < NUM_VECS) begin
      in_req = {vectors[drv_idx].add, vectors[drv_idx].a, vectors[drv_idx].b};
    end
    case (stall_mode)
      0: out_stall = 1'b0;
      1: out_stall = 1'b1;
      default: begin
        lcg_state = lcg_next(lcg_state);
        out_stall = lcg_state[31];
      end
    endcase
    #1;
    cycle_no++;
    if (idle_check) begin
      assert (!out_valid) else
        abort_run($sformatf("FAILED out_valid: got %h, expected %h", out_valid, 1'b0));
      assert (!in_stall) else
        abort_run($sformatf("FAILED in_stall: got %h, expected %h", in_stall, 1'b0));
    end
    if (in_stall) saw_in_stall = 1'b1;
    if (in_valid && !in_stall) begin
      acc_cycle = cycle_no;  // taken at the coming rising edge
      drv_idx++;
    end
    if (out_valid && first_out_cycle < 0) first_out_cycle = cycle_no;
    if (out_valid && !out_stall) begin
      assert (rsp_idx < NUM_VECS) else
        abort_run("a response arrived after every table entry was consumed");
      check_response(vectors[rsp_idx], rsp_idx);
      rsp_idx++;
    end
  endtask

  initial begin
    in_valid        = 1'b0;
    in_req          = '0;
    out_stall       = 1'b0;
    drv_idx         = 0;
    rsp_idx         = 0;
    drive_limit     = 0;
    stall_mode      = 0;
    cycle_no        = 0;
    acc_cycle       = -1;
    first_out_cycle = -1;
    idle_check      = 1'b1;
    saw_in_stall    = 1'b0;
    lcg_state       = 32'd31;

    // add  a      b      result z     n
    vectors[0]  = make_vec(1'b0, 8'h00, 8'h00, 8'h00, 1'b1, 1'b0);
    vectors[1]  = make_vec(1'b0, 8'h00, 8'h01, 8'hff, 1'b0, 1'b1);
    vectors[2]  = make_vec(1'b1, 8'hff, 8'h01, 8'h00, 1'b1, 1'b0);
    vectors[3]  = make_vec(1'b1, 8'h80, 8'h00, 8'h80, 1'b0, 1'b1);
    vectors[4]  = make_vec(1'b0, 8'h07, 8'h07, 8'h00, 1'b1, 1'b0);
    vectors[5]  = make_vec(1'b1, 8'h01, 8'h02, 8'h03, 1'b0, 1'b0);
    vectors[6]  = make_vec(1'b1, 8'h7f, 8'h01, 8'h80, 1'b0, 1'b1);
    vectors[7]  = make_vec(1'b0, 8'h80, 8'h01, 8'h7f, 1'b0, 1'b0);
    vectors[8]  = make_vec(1'b1, 8'h0f, 8'hf0, 8'hff, 1'b0, 1'b1);
    vectors[9]  = make_vec(1'b0, 8'h10, 8'h20, 8'hf0, 1'b0, 1'b1);
    vectors[10] = make_vec(1'b1, 8'h64, 8'h64, 8'hc8, 1'b0, 1'b1);
    vectors[11] = make_vec(1'b0, 8'hc8, 8'h64, 8'h64, 1'b0, 1'b0);
    vectors[12] = make_vec(1'b1, 8'hff, 8'hff, 8'hfe, 1'b0, 1'b1);
    vectors[13] = make_vec(1'b0, 8'h05, 8'h0a, 8'hfb, 1'b0, 1'b1);
    vectors[14] = make_vec(1'b1, 8'h12, 8'h34, 8'h46, 1'b0, 1'b0);
    vectors[15] = make_vec(1'b0, 8'h34, 8'h12, 8'h22, 1'b0, 1'b0);
    vectors[16] = make_vec(1'b1, 8'h80, 8'h80, 8'h00, 1'b1, 1'b0);
    vectors[17] = make_vec(1'b0, 8'hff, 8'hff, 8'h00, 1'b1, 1'b0);
    vectors[18] = make_vec(1'b1, 8'h3c, 8'h0a, 8'h46, 1'b0, 1'b0);
    vectors[19] = make_vec(1'b0, 8'h00, 8'h80, 8'h80, 1'b0, 1'b1);
    vectors[20] = make_vec(1'b1, 8'haa, 8'h55, 8'hff, 1'b0, 1'b1);
    vectors[21] = make_vec(1'b0, 8'h55, 8'haa, 8'hab, 1'b0, 1'b1);
    vectors[22] = make_vec(1'b1, 8'h01, 8'hfe, 8'hff, 1'b0, 1'b1);
    vectors[23] = make_vec(1'b0, 8'h9c, 8'h1c, 8'h80, 1'b0, 1'b1);

    // outputs stay quiet through reset and just after it
    do begin
      run_cycle();
    end while (rst);
    repeat (3) run_cycle();
    idle_check = 1'b0;

    // single request into an idle DUT
    drive_limit = 1;
    while (rsp_idx < 1) run_cycle();
    assert (first_out_cycle - acc_cycle == `PIPE_DEPTH + 1) else
      abort_run($sformatf("FAILED latency: got %h, expected %h",
                          first_out_cycle - acc_cycle, `PIPE_DEPTH + 1));

    // stream the rest against a blocked output
    drive_limit  = NUM_VECS;
    stall_mode   = 1;
    saw_in_stall = 1'b0;
    repeat (HOLD_CYCLES) run_cycle();
    assert (saw_in_stall) else
      abort_run("in_stall never rose while out_stall was held high");

    stall_mode = 2;
    while (rsp_idx < NUM_VECS) run_cycle();

    // anything still coming out now is a duplicate
    stall_mode = 0;
    repeat (2 * (`PIPE_DEPTH + 1)) run_cycle();

    $display("Simulation PASSED");
    $finish;
  end

  // 40 cycles per entry plus reset
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("timeout: run still going after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
logic/stream_pkg.sv
logic/flow_pkg.sv
logic/skid_buf.sv
logic/delay_line.sv
logic/arith_pipe.sv
logic/out_fifo.sv
logic/arith_stream_top.sv
tb/tb_clk_gen.sv
tb/arith_stream_tb.sv

// File: Bender.yml
package:
  name: arith_stream

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/stream_pkg.sv
      - logic/flow_pkg.sv
      - logic/skid_buf.sv
      - logic/delay_line.sv
      - logic/arith_pipe.sv
      - logic/out_fifo.sv
      - logic/arith_stream_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clk_gen.sv
      - tb/arith_stream_tb.sv
